/* design/uart_pkg.sv */
// uart frame format package
`default_nettype none

package uart_pkg;

  localparam int data_bits = 8;  // word length, fixed

  // parity_type codes
  // upper bit set means a parity bit goes out after the data
  // lower bit picks odd parity
  localparam logic [1:0] parity_none_0 = 2'b00;
  localparam logic [1:0] parity_none_1 = 2'b01;
  localparam logic [1:0] parity_even   = 2'b10;
  localparam logic [1:0] parity_odd    = 2'b11;

  // true when the frame carries a parity bit
  function automatic logic has_parity(input logic [1:0] ptype);
    logic en;
    case (ptype)
      parity_even, parity_odd:      en = 1'b1;
      parity_none_0, parity_none_1: en = 1'b0;
      default:                      en = 1'b0;
    endcase
    return en;
  endfunction

  // expected parity bit for a data word
  function automatic logic parity_of(input logic [data_bits-1:0] data,
                                     input logic [1:0] ptype);
    return (^data) ^ (ptype == parity_odd);  // invert xor for odd
  endfunction

endpackage

`default_nettype wire

/* design/uart_tx.sv */
// uart transmitter
`default_nettype none
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
  parameter int clks_per_bit = 8  // clock cycles per serial bit
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tx_en,        // transmitter enable
  input  logic [1:0]           parity_type,  // see uart_pkg codes
  input  logic                 nstop,        // 1 = two stop bits
  input  logic [data_bits-1:0] data_in,
  input  logic                 data_valid,   // level strobe from host
  output logic                 txd,          // serial out idling high
  output logic                 tx_rdy        // high only in idle
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int idx_w = $clog2(data_bits);

  // fsm encoding
  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_start  = 3'd1;
  localparam logic [2:0] st_data   = 3'd2;
  localparam logic [2:0] st_parity = 3'd3;
  localparam logic [2:0] st_stop1  = 3'd4;
  localparam logic [2:0] st_stop2  = 3'd5;

  logic [2:0]           state, next_state;
  logic [cnt_w-1:0]     bit_cnt;    // cycles into the current bit
  logic                 bit_end;    // last cycle of a bit period
  logic [idx_w-1:0]     data_cnt;   // data bit index
  logic [data_bits-1:0] shift_reg;  // parallel to serial
  logic                 tx_parity;  // parity bit for this frame
  logic                 accept;     // byte taken this edge

  assign accept  = (state == st_idle) & tx_en & data_valid;
  assign bit_end = (bit_cnt == cnt_w'(clks_per_bit - 1));

  // bit period timer restarts at acceptance
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bit_cnt <= '0;
    end else if (accept || bit_end) begin
      bit_cnt <= '0;
    end else if (state != st_idle) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // counts data bits sent
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      data_cnt <= '0;
    end else if (accept) begin
      data_cnt <= '0;
    end else if (state == st_data && bit_end) begin
      data_cnt <= data_cnt + 1'b1;
    end
  end

  // payload shift register
  always_ff @(posedge clock) begin
    if (accept) begin
      shift_reg <= data_in;
    end else if (state == st_data && bit_end) begin
      shift_reg <= {1'b0, shift_reg[data_bits-1:1]};  // lsb first
    end
  end

  // byte is stable during the start bit
  always_ff @(posedge clock) begin
    if (state == st_start) begin
      tx_parity <= parity_of(shift_reg, parity_type);
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // every move waits for bit_end except leaving idle
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (accept) next_state = st_start;
      end
      st_start: begin
        if (bit_end) next_state = st_data;
      end
      st_data: begin
        if (bit_end && data_cnt == idx_w'(data_bits - 1)) begin
          if (has_parity(parity_type)) next_state = st_parity;
          else next_state = st_stop1;
        end
      end
      st_parity: begin
        if (bit_end) next_state = st_stop1;
      end
      st_stop1: begin
        if (bit_end) next_state = nstop ? st_stop2 : st_idle;
      end
      st_stop2: begin
        if (bit_end) next_state = st_idle;
      end
      default: next_state = st_idle;
    endcase
  end

  // line level per state
  always_comb begin
    case (state)
      st_start:  txd = 1'b0;
      st_data:   txd = shift_reg[0];
      st_parity: txd = tx_parity;
      default:   txd = 1'b1;  // idle and stop bits
    endcase
  end

  assign tx_rdy = (state == st_idle);

  // line must idle high whenever the host may start a frame
  a_idle_high: assert property (@(posedge clock) disable iff (reset)
    tx_rdy |-> txd)
    else $error("uart_tx: txd low while tx_rdy high");

  a_state_legal: assert property (@(posedge clock) disable iff (reset)
    state <= st_stop2)
    else $error("uart_tx: illegal state code %0d", state);

endmodule

`default_nettype wire

/* design/uart_rx.sv */
// uart receiver
`default_nettype none
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
  parameter int clks_per_bit = 8  // clock cycles per serial bit
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rxd,            // async serial in
  input  logic [1:0]           parity_type,    // same codes as tx
  input  logic                 nstop,          // port symmetry with tx only
  output logic                 rx_done,        // one cycle, at stop bit centre
  output logic [data_bits-1:0] rx_byte,
  output logic                 rx_parity_bad,
  output logic                 rx_frame_bad    // first stop bit read low
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int idx_w = $clog2(data_bits);
  localparam int half  = clks_per_bit / 2;

  // fsm encoding
  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_start  = 3'd1;  // start bit check
  localparam logic [2:0] st_data   = 3'd2;
  localparam logic [2:0] st_parity = 3'd3;
  localparam logic [2:0] st_stop   = 3'd4;

  logic                 rxd_meta, rxd_sync, rxd_prev;
  logic                 fall;        // start edge seen
  logic [2:0]           state, next_state;
  logic [cnt_w-1:0]     cnt;         // sample timer
  logic                 tick;        // sample point this cycle
  logic [idx_w-1:0]     data_cnt;
  logic [data_bits-1:0] shift_reg;
  logic                 rx_par_bit;  // received parity bit

  // two flop synchronizer plus one for edge detect
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign fall = rxd_prev & ~rxd_sync;

  // half period for the start bit, full period after that
  assign tick = (state == st_start) ? (cnt == cnt_w'(half - 1))
                                    : (cnt == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cnt <= '0;
    end else if (state == st_idle || tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      data_cnt <= '0;
    end else if (state == st_start) begin
      data_cnt <= '0;
    end else if (state == st_data && tick) begin
      data_cnt <= data_cnt + 1'b1;
    end
  end

  // sampled payload
  always_ff @(posedge clock) begin
    if (state == st_data && tick) begin
      shift_reg <= {rxd_sync, shift_reg[data_bits-1:1]};  // lsb arrives first
    end
    if (state == st_parity && tick) begin
      rx_par_bit <= rxd_sync;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (fall) next_state = st_start;
      end
      st_start: begin
        if (tick) next_state = rxd_sync ? st_idle : st_data;  // glitch aborts
      end
      st_data: begin
        if (tick && data_cnt == idx_w'(data_bits - 1)) begin
          if (has_parity(parity_type)) next_state = st_parity;
          else next_state = st_stop;
        end
      end
      st_parity: begin
        if (tick) next_state = st_stop;
      end
      st_stop: begin
        if (tick) next_state = st_idle;  // a second stop bit reads as idle
      end
      default: next_state = st_idle;
    endcase
  end

  // results valid only while rx_done is high
  assign rx_done       = (state == st_stop) & tick;
  assign rx_byte       = shift_reg;
  assign rx_frame_bad  = ~rxd_sync;
  assign rx_parity_bad = has_parity(parity_type) &
                         (rx_par_bit != parity_of(shift_reg, parity_type));

  // a frame takes many cycles so completion can never repeat back to back
  a_done_single: assert property (@(posedge clock) disable iff (reset)
    rx_done |=> !rx_done)
    else $error("uart_rx: rx_done high two cycles in a row");

endmodule

`default_nettype wire

/* design/line_status.sv */
// receive line status
`default_nettype none
`timescale 1ns/1ps

module line_status import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rx_done,        // frame complete pulse
  input  logic [data_bits-1:0] rx_byte,
  input  logic                 rx_parity_bad,
  input  logic                 rx_frame_bad,
  input  logic                 rx_data_read,   // host read pulse
  input  logic                 status_clear,   // clears sticky flags
  output logic [data_bits-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 parity_error,
  output logic                 framing_error,
  output logic                 overrun
);

  // holding register, newest byte always wins
  always_ff @(posedge clock) begin
    if (rx_done) rx_data <= rx_byte;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_valid      <= 1'b0;
      parity_error  <= 1'b0;
      framing_error <= 1'b0;
      overrun       <= 1'b0;
    end else begin
      // new data beats a read in the same cycle
      if (rx_done) rx_valid <= 1'b1;
      else if (rx_data_read) rx_valid <= 1'b0;

      // sticky flags, set beats clear
      if (rx_done && rx_parity_bad) parity_error <= 1'b1;
      else if (status_clear) parity_error <= 1'b0;

      if (rx_done && rx_frame_bad) framing_error <= 1'b1;
      else if (status_clear) framing_error <= 1'b0;

      // unread byte overwritten
      if (rx_done && rx_valid && !rx_data_read) overrun <= 1'b1;
      else if (status_clear) overrun <= 1'b0;
    end
  end

  // overrun needs a byte still pending when it sets
  a_overrun_pending: assert property (@(posedge clock) disable iff (reset)
    $rose(overrun) |-> $past(rx_valid))
    else $error("line_status: overrun set with no pending byte");

endmodule

`default_nettype wire

/* design/uart_core.sv */
// uart top level
`default_nettype none
`timescale 1ns/1ps

module uart_core import uart_pkg::*; #(
  parameter int clks_per_bit = 8  // clock cycles per serial bit, at least 4
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tx_en,
  input  logic [1:0]           parity_type,   // shared by tx and rx
  input  logic                 nstop,
  input  logic [data_bits-1:0] data_in,
  input  logic                 data_valid,
  input  logic                 rxd,
  input  logic                 rx_data_read,
  input  logic                 status_clear,
  output logic                 txd,
  output logic                 tx_rdy,
  output logic [data_bits-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 parity_error,
  output logic                 framing_error,
  output logic                 overrun
);

  // receiver to status
  logic                 rx_done;
  logic [data_bits-1:0] rx_byte;
  logic                 rx_parity_bad;
  logic                 rx_frame_bad;

  uart_tx #(
    .clks_per_bit(clks_per_bit)
  ) uart_tx_inst (
    .clock       (clock),
    .reset       (reset),
    .tx_en       (tx_en),
    .parity_type (parity_type),
    .nstop       (nstop),
    .data_in     (data_in),
    .data_valid  (data_valid),
    .txd         (txd),
    .tx_rdy      (tx_rdy)
  );

  uart_rx #(
    .clks_per_bit(clks_per_bit)
  ) uart_rx_inst (
    .clock         (clock),
    .reset         (reset),
    .rxd           (rxd),
    .parity_type   (parity_type),
    .nstop         (nstop),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_parity_bad (rx_parity_bad),
    .rx_frame_bad  (rx_frame_bad)
  );

  line_status line_status_inst (
    .clock         (clock),
    .reset         (reset),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_parity_bad (rx_parity_bad),
    .rx_frame_bad  (rx_frame_bad),
    .rx_data_read  (rx_data_read),
    .status_clear  (status_clear),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .parity_error  (parity_error),
    .framing_error (framing_error),
    .overrun       (overrun)
  );

endmodule

`default_nettype wire

/* sim/uart_core_tb.sv */
// uart core testbench
`default_nettype none
`timescale 1ns/1ps

module uart_core_tb import uart_pkg::*; ();

  localparam int clks_per_bit = 8;
  localparam int half         = clks_per_bit / 2;
  localparam int max_wait     = 200 * clks_per_bit;  // cycles per wait
  localparam int w_tx_rdy     = 0;  // wait selectors
  localparam int w_rx_valid   = 1;
  localparam int w_overrun    = 2;

  logic       clock, reset, tx_en, nstop, data_valid;
  logic       rxd, rx_data_read, status_clear;
  logic [1:0] parity_type;
  logic [7:0] data_in, rx_data;
  logic       txd, tx_rdy, rx_valid;
  logic       parity_error, framing_error, overrun;

  logic       loop_sel;  // 1 = txd looped to rxd
  logic       inj_line;  // injected serial level
  int         mismatches;
  int         other_errors;
  int         seed;
  logic [1:0] codes [4];
  logic [7:0] byte_a, byte_b;

  assign rxd = loop_sel ? txd : inj_line;

  uart_core #(
    .clks_per_bit(clks_per_bit)
  ) uart_core_inst (
    .clock(clock), .reset(reset), .tx_en(tx_en), .parity_type(parity_type),
    .nstop(nstop), .data_in(data_in), .data_valid(data_valid), .rxd(rxd),
    .rx_data_read(rx_data_read), .status_clear(status_clear), .txd(txd),
    .tx_rdy(tx_rdy), .rx_data(rx_data), .rx_valid(rx_valid),
    .parity_error(parity_error), .framing_error(framing_error), .overrun(overrun)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  // idle outputs while reset is held
  a_reset_state: assert property (@(posedge clock)
    reset |-> (txd && tx_rdy && !rx_valid && !parity_error && !framing_error && !overrun))
    else begin
      other_errors++;
      $display("outputs not at their reset values during reset");
    end

  // a frame only starts on request
  a_start_requested: assert property (@(posedge clock) disable iff (reset)
    $fell(tx_rdy) |-> $past(tx_en && data_valid))
    else begin
      other_errors++;
      $display("transmitter left idle without an enabled data_valid");
    end

  task automatic step(input int n);
    repeat (n) @(posedge clock);
    #1;  // inputs and samples just after the edge
  endtask

  task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp)
      else begin
        mismatches++;
        $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
      end
  endtask

  function automatic logic watched(input int sel);
    case (sel)
      w_tx_rdy:   return tx_rdy;
      w_rx_valid: return rx_valid;
      default:    return overrun;
    endcase
  endfunction

  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    while (!watched(sel) && n < max_wait) begin
      step(1);
      n++;
    end
    if (!watched(sel)) begin
      other_errors++;
      $display("timeout waiting for %s", what);
    end
  endtask

  function automatic int frame_len(input logic [1:0] ptype, input logic two_stop);
    return 10 + int'(ptype[1]) + int'(two_stop);
  endfunction

  // line levels of one frame with bit 0 sent first
  function automatic logic [11:0] frame_levels(input logic [7:0] data, input logic [1:0] ptype);
    logic [11:0] f;
    f = '1;                          // stop bits high
    f[0] = 1'b0;                     // start
    f[8:1] = data;                   // lsb first
    if (ptype[1]) f[9] = (^data) ^ ptype[0];  // odd flips it
    return f;
  endfunction

  // send one byte and sample txd at every bit centre
  task automatic trace_frame(input logic [7:0] data, input logic [1:0] ptype,
                             input logic two_stop);
    logic [11:0] f;
    int n;
    f = frame_levels(data, ptype);
    n = frame_len(ptype, two_stop);
    wait_high(w_tx_rdy, "tx_rdy before frame");
    parity_type = ptype;
    nstop = two_stop;
    data_in = data;
    data_valid = 1'b1;
    step(1);  // accepting edge
    check("tx_rdy after accept", 8'd0, 8'(tx_rdy));
    step(half);
    for (int k = 0; k < n; k++) begin
      check($sformatf("frame %02h code %0d bit %0d", data, ptype, k), 8'(f[k]), 8'(txd));
      check("tx_rdy mid frame", 8'd0, 8'(tx_rdy));
      if (k == n - 1) data_valid = 1'b0;  // held the whole frame without a restart
      step(k == n - 1 ? half - 1 : clks_per_bit);
    end
    check("tx_rdy in last cycle", 8'd0, 8'(tx_rdy));
    step(1);
    check("tx_rdy after frame", 8'd1, 8'(tx_rdy));
  endtask

  task automatic send_byte(input logic [7:0] data);
    wait_high(w_tx_rdy, "tx_rdy");
    data_in = data;
    data_valid = 1'b1;
    step(1);
    data_valid = 1'b0;
  endtask

  task automatic pulse_read();
    rx_data_read = 1'b1;
    step(1);
    rx_data_read = 1'b0;
  endtask

  task automatic pulse_clear();
    status_clear = 1'b1;
    step(1);
    status_clear = 1'b0;
  endtask

  task automatic loop_byte(input logic [7:0] data);
    send_byte(data);
    wait_high(w_rx_valid, "rx_valid in loopback");
    check("loopback data", data, rx_data);
    check("loopback flags", 8'd0, {5'd0, parity_error, framing_error, overrun});
    pulse_read();
    check("rx_valid after read", 8'd0, 8'(rx_valid));
  endtask

  // one frame bit by bit onto rxd then idle
  task automatic inject_frame(input logic [7:0] data, input logic [1:0] ptype,
                              input logic par_flip, input logic stop_level);
    logic [11:0] f;
    int n;
    f = frame_levels(data, ptype);
    n = frame_len(ptype, 1'b0);
    if (ptype[1]) f[9] = f[9] ^ par_flip;
    f[n-1] = stop_level;
    for (int k = 0; k < n; k++) begin
      inj_line = f[k];
      step(clks_per_bit);
    end
    inj_line = 1'b1;
  endtask

  initial begin
    seed = 32'hec648857;
    mismatches = 0;
    other_errors = 0;
    codes = '{parity_none_0, parity_none_1, parity_even, parity_odd};
    reset = 1'b1;
    tx_en = 1'b0;
    parity_type = parity_none_0;
    nstop = 1'b0;
    data_in = 8'd0;
    data_valid = 1'b0;
    rx_data_read = 1'b0;
    status_clear = 1'b0;
    loop_sel = 1'b0;
    inj_line = 1'b1;  // idle line
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    check("after reset", 8'h30, {2'd0, txd, tx_rdy, rx_valid, parity_error,
                                 framing_error, overrun});

    // disabled transmitter ignores data_valid
    data_valid = 1'b1;
    step(clks_per_bit);
    check("tx_rdy while disabled", 8'd1, 8'(tx_rdy));
    data_valid = 1'b0;
    tx_en = 1'b1;

    // frame shape while the receiver sees an idle line
    for (int p = 0; p < 4; p++) begin
      for (int s = 0; s < 2; s++) begin
        repeat (2) trace_frame(8'($random(seed)), codes[p], 1'(s));
      end
    end

    // loopback under every code
    loop_sel = 1'b1;
    for (int p = 0; p < 4; p++) begin
      wait_high(w_tx_rdy, "tx_rdy before config change");
      parity_type = codes[p];
      nstop = 1'(p);
      repeat (3) loop_byte(8'($random(seed)));
    end

    // parity error injection
    wait_high(w_tx_rdy, "tx_rdy before injection");
    loop_sel = 1'b0;
    parity_type = parity_even;
    nstop = 1'b0;
    byte_a = 8'($random(seed));
    inject_frame(byte_a, parity_even, 1'b1, 1'b1);
    wait_high(w_rx_valid, "rx_valid after bad parity");
    check("parity error data", byte_a, rx_data);
    check("parity error flags", 8'h02, {6'd0, parity_error, framing_error});
    pulse_clear();
    check("parity_error after clear", 8'd0, 8'(parity_error));
    pulse_read();

    // framing error from a low stop bit
    parity_type = parity_none_0;
    inject_frame(8'($random(seed)), parity_none_0, 1'b0, 1'b0);
    wait_high(w_rx_valid, "rx_valid after bad stop bit");
    check("framing_error set", 8'd1, 8'(framing_error));
    step(3 * clks_per_bit);  // line held high
    check("framing_error sticky", 8'd1, 8'(framing_error));
    pulse_clear();
    check("framing_error after clear", 8'd0, 8'(framing_error));
    pulse_read();

    // overrun when the second byte lands unread
    loop_sel = 1'b1;
    parity_type = parity_even;
    byte_a = 8'($random(seed));
    byte_b = 8'($random(seed));
    send_byte(byte_a);
    wait_high(w_rx_valid, "rx_valid for first byte");
    check("first byte", byte_a, rx_data);
    send_byte(byte_b);
    wait_high(w_overrun, "overrun");
    check("overrun data", byte_b, rx_data);
    check("overrun rx_valid", 8'd1, 8'(rx_valid));
    pulse_read();
    pulse_clear();
    check("overrun after clear", 8'd0, 8'(overrun));

    $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
    if (mismatches + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/line_status.sv
design/uart_core.sv
sim/uart_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = uart_core_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
